// ==== design/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

    ////////////////////
    // Widths
    ////////////////////

    localparam int REG_ADD_WIDTH   = 5;
    localparam int LOAD_TYPE_WIDTH = 3;
    localparam int DM_STAGES       = 3;

    ////////////////////
    // Load encoding
    ////////////////////

    // Zero means the instruction is not a load
    typedef enum logic [LOAD_TYPE_WIDTH-1:0] {
        load_none   = 3'd0,
        load_byte   = 3'd1,
        load_half   = 3'd2,
        load_word   = 3'd3,
        load_byte_u = 3'd4,
        load_half_u = 3'd5
    } load_type_e;

    ////////////////////
    // Pipeline records
    ////////////////////

    typedef struct packed {
        logic                     valid;
        logic [REG_ADD_WIDTH-1:0] rs1;
        logic [REG_ADD_WIDTH-1:0] rs2;
        logic [REG_ADD_WIDTH-1:0] rd;
        load_type_e               load_type;
    } ex_instr_t;

    typedef struct packed {
        logic [REG_ADD_WIDTH-1:0] rd;
        load_type_e               load_type;
    } dm_record_t;

    // Bubble in a data-memory stage
    localparam dm_record_t DM_EMPTY = '{rd: '0, load_type: load_none};

    typedef struct packed {
        dm_record_t dm1;
        dm_record_t dm2;
        dm_record_t dm3;
    } dm_pipe_t;

    typedef struct packed {
        logic clear_fetch;
        logic clear_decode;
        logic clear_execute;
        logic stall_pc;
        logic stall_icache;
        logic stall_fetch;
        logic stall_decode;
        logic stall_execute;
        logic stall_data_memory;
    } stage_ctrl_t;

endpackage

`default_nettype wire

// ==== design/mem_stage_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tracker (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire hazard_pkg::ex_instr_t ex,
    input  wire logic                 dcache_ready,
    input  wire logic                 clear_execute,
    output hazard_pkg::dm_pipe_t      dm
);

    hazard_pkg::dm_record_t next_dm1;
    hazard_pkg::dm_pipe_t   dm_q;

    ////////////////////
    // Entry into DM1
    ////////////////////

    // Cleared or empty execute slot becomes a bubble
    always_comb
    begin
        if (!ex.valid || clear_execute)
        begin
            next_dm1 = hazard_pkg::DM_EMPTY;
        end
        else
        begin
            next_dm1.rd        = ex.rd;
            next_dm1.load_type = ex.load_type;
        end
    end

    ////////////////////
    // DM1 to DM3 shift
    ////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dm_q.dm1 <= hazard_pkg::DM_EMPTY;
            dm_q.dm2 <= hazard_pkg::DM_EMPTY;
            dm_q.dm3 <= hazard_pkg::DM_EMPTY;
        end
        else if (dcache_ready)
        begin
            dm_q.dm3 <= dm_q.dm2;
            dm_q.dm2 <= dm_q.dm1;
            dm_q.dm1 <= next_dm1;
        end
        // Data cache miss holds every stage
    end

    assign dm = dm_q;

    ////////////////////
    // Checks
    ////////////////////

    a_hold_on_miss : assert property (
        @(posedge clk) disable iff (!arst_n)
        !dcache_ready |=> $stable(dm_q)
    );

endmodule

`default_nettype wire

// ==== design/load_use_detector.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_use_detector (
    input  wire hazard_pkg::ex_instr_t ex,
    input  wire hazard_pkg::dm_pipe_t  dm,
    output logic                       load_use_hazard
);

    hazard_pkg::dm_record_t [hazard_pkg::DM_STAGES-1:0] recs;
    logic [hazard_pkg::DM_STAGES-1:0]                   is_source;
    logic [hazard_pkg::DM_STAGES-1:0]                   hit;

    // Youngest record at index 0
    assign recs[0] = dm.dm1;
    assign recs[1] = dm.dm2;
    assign recs[2] = dm.dm3;

    ////////////////////
    // Per-stage compare
    ////////////////////

    for (genvar i = 0; i < hazard_pkg::DM_STAGES; i++)
    begin : g_cmp
        // x0 never carries a result
        assign is_source[i] = (recs[i].load_type != hazard_pkg::load_none)
                           && (recs[i].rd != '0);

        assign hit[i] = is_source[i]
                     && ((ex.rs1 == recs[i].rd) || (ex.rs2 == recs[i].rd));
    end

    assign load_use_hazard = ex.valid && (|hit);

    ////////////////////
    // Checks
    ////////////////////

    always_comb
    begin
        a_no_hazard_when_idle : assert final (ex.valid || !load_use_hazard);
    end

endmodule

`default_nettype wire

// ==== design/redirect_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module redirect_unit (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic pc_mispredicted,
    input  wire logic frontend_hold,
    output logic      redirect_req
);

    logic pending;

    // Live mispredict or one that is still waiting
    assign redirect_req = pc_mispredicted || pending;

    ////////////////////
    // Pending flag
    ////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pending <= 1'b0;
        end
        else if (redirect_req)
        begin
            if (frontend_hold)
            begin
                pending <= 1'b1;
            end
            else
            begin
                // Front end took the redirect
                pending <= 1'b0;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_pending_needs_hold : assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(pending) |-> $past(frontend_hold)
    );

endmodule

`default_nettype wire

// ==== design/stall_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module stall_merge (
    input  wire logic             load_use_hazard,
    input  wire logic             redirect_req,
    input  wire logic             icache_ready,
    input  wire logic             dcache_ready,
    output hazard_pkg::stage_ctrl_t ctrl,
    output logic                  frontend_hold
);

    // Front end cannot accept a new PC during either miss
    assign frontend_hold = !dcache_ready || !icache_ready;

    ////////////////////
    // Priority merge
    ////////////////////

    always_comb
    begin
        ctrl = '0;

        if (!dcache_ready)
        begin
            // Whole pipe freezes
            ctrl.stall_pc          = 1'b1;
            ctrl.stall_icache      = 1'b1;
            ctrl.stall_fetch       = 1'b1;
            ctrl.stall_decode      = 1'b1;
            ctrl.stall_execute     = 1'b1;
            ctrl.stall_data_memory = 1'b1;
        end
        else
        begin
            if (load_use_hazard)
            begin
                // Bubble into DM1 while older stages keep moving
                ctrl.clear_execute = 1'b1;
                ctrl.stall_pc      = 1'b1;
                ctrl.stall_icache  = 1'b1;
                ctrl.stall_fetch   = 1'b1;
                ctrl.stall_decode  = 1'b1;
                ctrl.stall_execute = 1'b1;
            end

            if (!icache_ready)
            begin
                ctrl.stall_pc     = 1'b1;
                ctrl.stall_icache = 1'b1;
                ctrl.stall_fetch  = 1'b1;
            end
            else if (redirect_req)
            begin
                // Flush wins over the front stalls
                ctrl.clear_fetch  = 1'b1;
                ctrl.clear_decode = 1'b1;
                ctrl.stall_fetch  = 1'b0;
                ctrl.stall_decode = 1'b0;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    always_comb
    begin
        a_fetch_excl : assert final (!(ctrl.clear_fetch && ctrl.stall_fetch));
    end

    always_comb
    begin
        a_decode_excl : assert final (!(ctrl.clear_decode && ctrl.stall_decode));
    end

endmodule

`default_nettype wire

// ==== design/hazard_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_subsystem (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire hazard_pkg::ex_instr_t ex,
    input  wire logic                  pc_mispredicted,
    input  wire logic                  icache_ready,
    input  wire logic                  dcache_ready,
    output hazard_pkg::stage_ctrl_t    ctrl
);

    hazard_pkg::dm_pipe_t    dm;
    hazard_pkg::stage_ctrl_t ctrl_int;
    logic                    load_use_hazard;
    logic                    redirect_req;
    logic                    frontend_hold;

    ////////////////////
    // In-flight loads
    ////////////////////

    mem_stage_tracker u_tracker (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex            (ex),
        .dcache_ready  (dcache_ready),
        .clear_execute (ctrl_int.clear_execute),
        .dm            (dm)
    );

    ////////////////////
    // Checkers
    ////////////////////

    load_use_detector u_detector (
        .ex              (ex),
        .dm              (dm),
        .load_use_hazard (load_use_hazard)
    );

    redirect_unit u_redirect (
        .clk             (clk),
        .arst_n          (arst_n),
        .pc_mispredicted (pc_mispredicted),
        .frontend_hold   (frontend_hold),
        .redirect_req    (redirect_req)
    );

    ////////////////////
    // Control word
    ////////////////////

    stall_merge u_merge (
        .load_use_hazard (load_use_hazard),
        .redirect_req    (redirect_req),
        .icache_ready    (icache_ready),
        .dcache_ready    (dcache_ready),
        .ctrl            (ctrl_int),
        .frontend_hold   (frontend_hold)
    );

    assign ctrl = ctrl_int;

endmodule

`default_nettype wire

// ==== test/tb_hazard_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_hazard_subsystem;

    logic                    clk;
    logic                    arst_n;
    hazard_pkg::ex_instr_t   ex;
    logic                    pc_mispredicted;
    logic                    icache_ready;
    logic                    dcache_ready;
    hazard_pkg::stage_ctrl_t ctrl;

    // Reference state of the DM record and the pending redirect
    hazard_pkg::dm_pipe_t    model_dm;
    logic                    model_pending;
    logic                    exp_hazard;
    hazard_pkg::stage_ctrl_t exp_ctrl;

    integer seed;
    int     errors;
    int     hazard_cycles;
    int     flush_cycles;
    int     freeze_cycles;

    hazard_subsystem dut0 (
        .clk             (clk),
        .arst_n          (arst_n),
        .ex              (ex),
        .pc_mispredicted (pc_mispredicted),
        .icache_ready    (icache_ready),
        .dcache_ready    (dcache_ready),
        .ctrl            (ctrl)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Real load into x1..x31 read by the execute instruction
    function automatic logic rec_blocks(input hazard_pkg::dm_record_t rec,
                                        input hazard_pkg::ex_instr_t e);
        logic live;
        live = (rec.load_type != hazard_pkg::load_none) && (rec.rd != 5'd0);
        return live && ((e.rs1 == rec.rd) || (e.rs2 == rec.rd));
    endfunction

    function automatic hazard_pkg::stage_ctrl_t build_ctrl(input logic hazard,
                                                           input logic redirect,
                                                           input logic ic,
                                                           input logic dc);
        logic                    hold;
        logic                    flush;
        logic                    bubble;
        hazard_pkg::stage_ctrl_t c;
        hold   = !dc || !ic;
        flush  = dc && ic && redirect;
        bubble = dc && hazard;
        c.clear_fetch       = flush;
        c.clear_decode      = flush;
        c.clear_execute     = bubble;
        c.stall_pc          = hold || bubble;
        c.stall_icache      = hold || bubble;
        c.stall_fetch       = (hold || bubble) && !flush;
        c.stall_decode      = (!dc || bubble) && !flush;
        c.stall_execute     = !dc || bubble;
        c.stall_data_memory = !dc;
        return c;
    endfunction

    always_comb
    begin
        exp_hazard = ex.valid && (rec_blocks(model_dm.dm1, ex)
                              || rec_blocks(model_dm.dm2, ex)
                              || rec_blocks(model_dm.dm3, ex));
        exp_ctrl   = build_ctrl(exp_hazard, pc_mispredicted || model_pending,
                                icache_ready, dcache_ready);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            model_dm      <= '0;
            model_pending <= 1'b0;
        end
        else
        begin
            if (dcache_ready)
            begin
                model_dm.dm3 <= model_dm.dm2;
                model_dm.dm2 <= model_dm.dm1;
                if (ex.valid && !exp_ctrl.clear_execute)
                begin
                    model_dm.dm1.rd        <= ex.rd;
                    model_dm.dm1.load_type <= ex.load_type;
                end
                else
                begin
                    model_dm.dm1 <= '0;
                end
            end
            // Redirect waits while the front end is held
            if (pc_mispredicted || model_pending)
            begin
                model_pending <= !dcache_ready || !icache_ready;
            end
        end
    end

    always @(posedge clk)
    begin
        if (arst_n)
        begin
            hazard_cycles <= hazard_cycles + (exp_ctrl.clear_execute ? 1 : 0);
            flush_cycles  <= flush_cycles + (exp_ctrl.clear_fetch ? 1 : 0);
            freeze_cycles <= freeze_cycles + (!dcache_ready ? 1 : 0);
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    a_ctrl_matches : assert property (
        @(posedge clk) disable iff (!arst_n)
        ctrl == exp_ctrl
    )
    else
    begin
        errors++;
        $display("CHECK FAILED at %0t: ctrl %b, expected %b",
                 $time, $sampled(ctrl), $sampled(exp_ctrl));
    end

    // Data cache miss freezes every stage and clears nothing
    a_miss_freezes : assert property (
        @(posedge clk) disable iff (!arst_n)
        dcache_ready || (ctrl[8:6] == 3'b000 && ctrl[5:0] == 6'b111111)
    )
    else
    begin
        errors++;
        $display("CHECK FAILED at %0t: ctrl %b during a data cache miss",
                 $time, $sampled(ctrl));
    end

    a_flush_unstalled : assert property (
        @(posedge clk) disable iff (!arst_n)
        !ctrl.clear_fetch || (!ctrl.stall_fetch && !ctrl.stall_decode)
    )
    else
    begin
        errors++;
        $display("CHECK FAILED at %0t: flush with fetch or decode stalled", $time);
    end

    a_pending_flushes : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(dcache_ready && icache_ready && model_pending)
            || (ctrl.clear_fetch && ctrl.clear_decode)
    )
    else
    begin
        errors++;
        $display("CHECK FAILED at %0t: pending redirect not flushed", $time);
    end

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic hazard_pkg::ex_instr_t make_instr(input logic v,
                                                         input logic [4:0] rs1,
                                                         input logic [4:0] rs2,
                                                         input logic [4:0] rd,
                                                         input hazard_pkg::load_type_e lt);
        hazard_pkg::ex_instr_t i;
        i.valid     = v;
        i.rs1       = rs1;
        i.rs2       = rs2;
        i.rd        = rd;
        i.load_type = lt;
        return i;
    endfunction

    task automatic drive_cycle(input hazard_pkg::ex_instr_t e, input logic mis,
                               input logic ic, input logic dc);
        @(posedge clk);
        ex              <= e;
        pc_mispredicted <= mis;
        icache_ready    <= ic;
        dcache_ready    <= dc;
    endtask

    task automatic wait_for_flush(input int limit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit)
        begin
            @(negedge clk);
            seen = ctrl.clear_fetch;
            n++;
        end
        if (!seen)
        begin
            errors++;
            $display("Timeout: no front-end flush within %0d cycles after the miss", limit);
        end
    endtask

    // Mispredict arrives during a miss and drops before the miss ends
    task automatic redirect_during_miss(input logic ic, input logic dc,
                                        input hazard_pkg::ex_instr_t nop);
        drive_cycle(nop, 1'b1, ic, dc);
        repeat (2) drive_cycle(nop, 1'b0, ic, dc);
        drive_cycle(nop, 1'b0, 1'b1, 1'b1);
        wait_for_flush(5);
        repeat (2) drive_cycle(nop, 1'b0, 1'b1, 1'b1);
    endtask

    initial
    begin
        hazard_pkg::ex_instr_t nop;
        hazard_pkg::ex_instr_t rnd_instr;
        logic [31:0]           r;
        logic [2:0]            lt_bits;

        seed            = 88;
        errors          = 0;
        hazard_cycles   = 0;
        flush_cycles    = 0;
        freeze_cycles   = 0;
        arst_n          = 1'b0;
        ex              = '0;
        pc_mispredicted = 1'b0;
        icache_ready    = 1'b1;
        dcache_ready    = 1'b1;
        nop = make_instr(1'b0, 5'd0, 5'd0, 5'd0, hazard_pkg::load_none);

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Quiet pipe after reset
        repeat (4) drive_cycle(nop, 1'b0, 1'b1, 1'b1);

        // Load into x3, one unrelated op, then a reader held while stalled
        drive_cycle(make_instr(1'b1, 5'd1, 5'd2, 5'd3, hazard_pkg::load_word), 1'b0, 1'b1, 1'b1);
        drive_cycle(make_instr(1'b1, 5'd4, 5'd5, 5'd6, hazard_pkg::load_none), 1'b0, 1'b1, 1'b1);
        repeat (3) drive_cycle(make_instr(1'b1, 5'd3, 5'd0, 5'd7, hazard_pkg::load_none),
                               1'b0, 1'b1, 1'b1);

        // x0 load and plain ALU writes never stall
        drive_cycle(make_instr(1'b1, 5'd1, 5'd1, 5'd0, hazard_pkg::load_half), 1'b0, 1'b1, 1'b1);
        drive_cycle(make_instr(1'b1, 5'd1, 5'd1, 5'd2, hazard_pkg::load_none), 1'b0, 1'b1, 1'b1);
        drive_cycle(make_instr(1'b1, 5'd0, 5'd2, 5'd8, hazard_pkg::load_none), 1'b0, 1'b1, 1'b1);
        repeat (3) drive_cycle(nop, 1'b0, 1'b1, 1'b1);

        // Mispredict with both caches ready
        drive_cycle(nop, 1'b1, 1'b1, 1'b1);
        repeat (2) drive_cycle(nop, 1'b0, 1'b1, 1'b1);

        // Hazard seen before a data miss lasts through it
        drive_cycle(make_instr(1'b1, 5'd1, 5'd2, 5'd5, hazard_pkg::load_byte_u), 1'b0, 1'b1, 1'b1);
        drive_cycle(make_instr(1'b1, 5'd0, 5'd5, 5'd9, hazard_pkg::load_none), 1'b0, 1'b1, 1'b1);
        repeat (3) drive_cycle(make_instr(1'b1, 5'd0, 5'd5, 5'd9, hazard_pkg::load_none),
                               1'b0, 1'b1, 1'b0);
        repeat (3) drive_cycle(make_instr(1'b1, 5'd0, 5'd5, 5'd9, hazard_pkg::load_none),
                               1'b0, 1'b1, 1'b1);
        repeat (3) drive_cycle(nop, 1'b0, 1'b1, 1'b1);

        redirect_during_miss(1'b1, 1'b0, nop);
        redirect_during_miss(1'b0, 1'b1, nop);

        // Mixed random traffic on registers x0..x3
        repeat (600)
        begin
            r       = $random(seed);
            lt_bits = (r[10:8] > 3'd5) ? 3'd0 : r[10:8];
            rnd_instr = make_instr(r[0] | r[1], {3'b000, r[3:2]}, {3'b000, r[5:4]},
                                   {3'b000, r[7:6]}, hazard_pkg::load_type_e'(lt_bits));
            drive_cycle(rnd_instr, r[13:11] == 3'd0, r[16:14] != 3'd0, r[19:17] != 3'd0);
        end
        repeat (3) drive_cycle(nop, 1'b0, 1'b1, 1'b1);
        @(posedge clk);

        if (hazard_cycles == 0 || flush_cycles == 0 || freeze_cycles == 0)
        begin
            errors++;
            $display("Stimulus never reached a load-use stall, a flush or a data miss");
        end

        $display("Errors: %0d, load-use cycles: %0d, flush cycles: %0d, freeze cycles: %0d",
                 errors, hazard_cycles, flush_cycles, freeze_cycles);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/hazard_pkg.sv
design/mem_stage_tracker.sv
design/load_use_detector.sv
design/redirect_unit.sv
design/stall_merge.sv
design/hazard_subsystem.sv
test/tb_hazard_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hazard subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_hazard_subsystem \
    -f sources.f \
    -o sim_hazard

./obj_dir/sim_hazard 2>&1 | tee sim.log

if grep -q "^Everything OK$" sim.log
then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
